// ==== all.f ====
+incdir+verif
hw/sh_lsab_pkg.sv
hw/lsab_wr_if.sv
hw/sh_rx_word_adaptor.sv
hw/sh_collision_drain.sv
hw/lsab_rx_queue.sv
hw/sh_lsab_bridge.sv
verif/tb_sh_lsab_bridge.sv

// ==== hw/lsab_rx_queue.sv ====
`timescale 1ns/1ns

module lsab_rx_queue (
	input  logic                           CLK,
	input  logic                           RST,
	input  logic [sh_lsab_pkg::TURN_W-1:0] lsab_turn,
	lsab_wr_if.buffer                      lsab,
	input  logic                           rx_pop,
	output logic [sh_lsab_pkg::WORD_W-1:0] rx_word,
	output logic                           rx_last,
	output logic                           rx_ok,
	output logic                           rx_empty,
	output logic                           rx_overflow
);
	import sh_lsab_pkg::*;

	// Entry layout is {ok, last, word}.
	logic [WORD_W+1:0] mem [RXQ_DEPTH];   // Circular store.
	logic [WORD_W+1:0] rd_entry;          // Oldest entry.
	logic [RXQ_AW:0]   wr_ptr;            // Write pointer plus wrap bit.
	logic [RXQ_AW:0]   rd_ptr;            // Read pointer plus wrap bit.
	logic              accept;            // Word taken from the LSAB.
	logic              full;
	logic              push;
	logic              pop;
	logic              ok_flag;           // Good flag only on frame end.

	assign lsab.slot = lsab_turn == CR_SLOT;      // Receive slot decode.

	assign accept  = lsab.write & lsab.slot;
	assign full    = (wr_ptr[RXQ_AW] != rd_ptr[RXQ_AW])
		&& (wr_ptr[RXQ_AW-1:0] == rd_ptr[RXQ_AW-1:0]);   // Same slot, other lap.
	assign push    = accept & ~full;
	assign pop     = rx_pop & ~rx_empty;
	assign ok_flag = lsab.irq & lsab.irq_vld;

	assign rx_empty = wr_ptr == rd_ptr;
	assign rd_entry = mem[rd_ptr[RXQ_AW-1:0]];    // Shown-ahead.
	assign rx_word  = rd_entry[WORD_W-1:0];
	assign rx_last  = rd_entry[WORD_W];
	assign rx_ok    = rd_entry[WORD_W+1];

	always_ff @(posedge CLK)
	begin
		if (push)
			mem[wr_ptr[RXQ_AW-1:0]] <= {ok_flag, lsab.irq, lsab.data};
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			rx_overflow <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;          // Next free entry.
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;          // Next oldest.
			if (accept && full)
				rx_overflow <= 1'b1;              // Word lost, sticky.
		end
	end

endmodule

// ==== hw/lsab_wr_if.sv ====
`timescale 1ns/1ns

interface lsab_wr_if;
	import sh_lsab_pkg::*;

	logic [WORD_W-1:0] data;    // Word offered to the LSAB.
	logic              write;   // Word pending, level until taken in slot.
	logic              irq;     // Frame end, travels with the last word.
	logic              irq_vld; // Frame good flag for the irq.
	logic              slot;    // Receive path owns the LSAB this cycle.

	// Word producer side.
	modport adaptor (
		output data,
		output write,
		output irq,
		output irq_vld,
		input  slot
	);

	// Buffer side, also decodes the slot.
	modport buffer (
		input  data,
		input  write,
		input  irq,
		input  irq_vld,
		output slot
	);

endinterface

// ==== hw/sh_collision_drain.sv ====
`timescale 1ns/1ns

module sh_collision_drain (
	input  logic                           CLK,
	input  logic                           RST,
	input  logic [sh_lsab_pkg::TURN_W-1:0] lsab_turn,
	input  logic                           collision,
	input  logic                           mac_read,
	input  logic                           err_ack,
	output logic                           err_req,
	output logic                           lsab_read
);
	import sh_lsab_pkg::*;

	// Reads from the MAC are short pulses, the LSAB needs a level that
	// holds until the transmit slot. A toggle pair does that. After a
	// collision the rest of the frame sits in the LSAB and gets drained.

	logic               coll_r;       // Collision, first stage.
	logic               coll_prev;    // Collision, second stage.
	logic               read_r;       // MAC read, first stage.
	logic               read_prev;    // MAC read, second stage.
	logic               coll_evt;     // Rising collision.
	logic               read_evt;     // Rising MAC read.
	logic               read_req;     // Flips per MAC read.
	logic               read_ack;     // Follows read_req in slot.
	logic               read_regular; // Regular read pending.
	logic               read_drain;   // Drain in progress.
	logic               my_turn;      // Transmit slot.
	logic [DRAIN_W-1:0] drain_cnt;    // Owned slots drained so far.

	assign my_turn      = lsab_turn == CW_SLOT;
	assign coll_evt     = coll_r & ~coll_prev;
	assign read_evt     = read_r & ~read_prev;
	assign read_regular = read_req ^ read_ack;     // Request outstanding.
	assign read_drain   = ~drain_cnt[DRAIN_W-1];   // Top bit clear while busy.
	assign lsab_read    = read_drain | read_regular;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			coll_r    <= 1'b0;
			coll_prev <= 1'b0;
			read_r    <= 1'b0;
			read_prev <= 1'b0;
			read_req  <= 1'b0;
			read_ack  <= 1'b0;
			err_req   <= 1'b0;
			drain_cnt <= DRAIN_W'(DRAIN_WORDS);   // Idle.
		end
		else
		begin
			coll_r    <= collision;              // Sync stage.
			coll_prev <= coll_r;                 // Edge reference.
			read_r    <= mac_read;               // Sync stage.
			read_prev <= read_r;                 // Edge reference.

			if (read_evt)
				read_req <= ~read_req;           // New request.
			if (lsab_read && my_turn)
				read_ack <= read_req;            // Served in slot.

			if (read_drain && lsab_read && my_turn)
				drain_cnt <= drain_cnt + 1'b1;   // One word gone.

			// Acknowledge restarts the drain, wins over the count.
			if (err_req && err_ack)
				drain_cnt <= '0;

			if (coll_evt)
				err_req <= 1'b1;                 // Ask the host.
			else if (err_ack)
				err_req <= 1'b0;                 // Answered.
		end
	end

endmodule

// ==== hw/sh_lsab_bridge.sv ====
`timescale 1ns/1ns

module sh_lsab_bridge (
	input  logic                           CLK,
	input  logic                           RST,
	input  logic [sh_lsab_pkg::TURN_W-1:0] lsab_turn,     // Slot owner now.
	// MAC receive side.
	input  logic [sh_lsab_pkg::WORD_W-1:0] eth_data,
	input  logic                           eth_write,
	input  logic                           eth_frame_end,
	input  logic                           eth_frame_ok,
	// Receive consumer.
	input  logic                           rx_pop,
	output logic [sh_lsab_pkg::WORD_W-1:0] rx_word,
	output logic                           rx_last,
	output logic                           rx_ok,
	output logic                           rx_empty,
	output logic                           rx_overflow,
	// MAC transmit side.
	input  logic                           collision,
	input  logic                           mac_read,
	input  logic                           err_ack,
	output logic                           err_req,
	// LSAB read line.
	output logic                           lsab_read
);

	lsab_wr_if lsab_wr ();   // Adaptor to queue write port.

	// Receive words into the LSAB.
	sh_rx_word_adaptor i_rx_adaptor (
		.CLK           (CLK),
		.RST           (RST),
		.eth_data      (eth_data),
		.eth_write     (eth_write),
		.eth_frame_end (eth_frame_end),
		.eth_frame_ok  (eth_frame_ok),
		.lsab          (lsab_wr)
	);

	// Stand-in for the LSAB receive buffer.
	lsab_rx_queue i_rx_queue (
		.CLK         (CLK),
		.RST         (RST),
		.lsab_turn   (lsab_turn),
		.lsab        (lsab_wr),
		.rx_pop      (rx_pop),
		.rx_word     (rx_word),
		.rx_last     (rx_last),
		.rx_ok       (rx_ok),
		.rx_empty    (rx_empty),
		.rx_overflow (rx_overflow)
	);

	// Transmit reads and collision drain.
	sh_collision_drain i_tx_drain (
		.CLK       (CLK),
		.RST       (RST),
		.lsab_turn (lsab_turn),
		.collision (collision),
		.mac_read  (mac_read),
		.err_ack   (err_ack),
		.err_req   (err_req),
		.lsab_read (lsab_read)
	);

endmodule

// ==== hw/sh_lsab_pkg.sv ====
package sh_lsab_pkg;

	// Data path width on both the MAC and the LSAB side.
	localparam int WORD_W = 32;

	// LSAB turn number width. The turn rotates over four slots.
	localparam int TURN_W = 2;

	// Receive path owns the LSAB in this slot.
	localparam logic [TURN_W-1:0] CR_SLOT = 2'd0;

	// Transmit path owns the LSAB in this slot.
	localparam logic [TURN_W-1:0] CW_SLOT = 2'd0;

	// Words thrown away after an acknowledged collision.
	localparam int DRAIN_WORDS = 128;

	// Drain counter width. Top bit set means idle.
	localparam int DRAIN_W = 8;

	// Receive queue size.
	localparam int RXQ_DEPTH = 16;

	// Queue address width without the wrap bit.
	localparam int RXQ_AW = 4;

endpackage

// ==== hw/sh_rx_word_adaptor.sv ====
`timescale 1ns/1ns

module sh_rx_word_adaptor (
	input  logic                           CLK,
	input  logic                           RST,
	input  logic [sh_lsab_pkg::WORD_W-1:0] eth_data,
	input  logic                           eth_write,
	input  logic                           eth_frame_end,
	input  logic                           eth_frame_ok,
	lsab_wr_if.adaptor                     lsab
);
	import sh_lsab_pkg::*;

	// The MAC signals frame end only after the last write, while the LSAB
	// wants the irq together with the last word. So every word is held
	// back by one event and pushed out by the next write or frame end.

	logic [WORD_W-1:0] holder;      // One word held back.
	logic              write_r;     // Write strobe, first stage.
	logic              write_prev;  // Write strobe, second stage.
	logic              fend_r;      // Frame end, first stage.
	logic              fend_prev;   // Frame end, second stage.
	logic              fok_r;       // Frame good, aligned with fend_r.
	logic              write_evt;   // Rising write strobe.
	logic              fend_evt;    // Rising frame end.
	logic              fend_seen;   // Frame end event, one cycle later.
	logic              capture_arm; // Take eth_data at next slot.
	logic              first_seen;  // A write came in this frame.
	logic              holder_full; // Holder has a word worth sending.
	logic              push_held;   // Send the held word.
	logic              write_lvl;   // Level towards the LSAB.
	logic              irq_lvl;     // Irq level towards the LSAB.
	logic              irq_vld_r;   // Frame good, sampled at frame end.

	assign write_evt = write_r & ~write_prev;              // Edge detect.
	assign fend_evt  = fend_r & ~fend_prev;                // Edge detect.
	assign push_held = (write_evt | fend_seen) & holder_full; // Older word out.

	assign lsab.data    = holder;
	assign lsab.write   = write_lvl;
	assign lsab.irq     = irq_lvl;
	assign lsab.irq_vld = irq_vld_r;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			write_r     <= 1'b0;
			write_prev  <= 1'b0;
			fend_r      <= 1'b0;
			fend_prev   <= 1'b0;
			fok_r       <= 1'b0;
			fend_seen   <= 1'b0;
			capture_arm <= 1'b0;
			first_seen  <= 1'b0;
			holder_full <= 1'b0;
			write_lvl   <= 1'b0;
			irq_lvl     <= 1'b0;
			irq_vld_r   <= 1'b0;
		end
		else
		begin
			write_r    <= eth_write;           // Sync stage.
			write_prev <= write_r;             // Edge reference.
			fend_r     <= eth_frame_end;       // Sync stage.
			fend_prev  <= fend_r;              // Edge reference.
			fok_r      <= eth_frame_ok;        // Travels with fend_r.
			fend_seen  <= fend_evt;            // Delay for irq.

			if (fend_evt)
				irq_vld_r <= fok_r;                // Good flag at frame end.

			if (fend_seen)
				irq_lvl <= 1'b1;                   // Arm irq.
			else if (lsab.slot)
				irq_lvl <= 1'b0;                   // Taken in slot.

			if (write_evt)
				capture_arm <= 1'b1;               // New word waiting.
			else if (lsab.slot)
				capture_arm <= 1'b0;               // Captured in slot.

			if (push_held)
				write_lvl <= 1'b1;                 // Offer held word.
			else if (lsab.slot)
				write_lvl <= 1'b0;                 // Taken in slot.

			// Last word leaves with the irq, frame is over then.
			if (irq_lvl && lsab.slot)
			begin
				holder_full <= 1'b0;
				first_seen  <= 1'b0;
			end
			else
			begin
				if (write_evt)
					first_seen <= 1'b1;            // Frame has data.
				if (first_seen && lsab.slot)
					holder_full <= 1'b1;           // First word is in.
			end
		end
	end

	// Holder only loads in the receive slot, same edge the old word leaves.
	always_ff @(posedge CLK)
	begin
		if (capture_arm && lsab.slot)
			holder <= eth_data;
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the LSAB bridge testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ns -f all.f --top-module tb_sh_lsab_bridge -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== verif/tb_sh_lsab_tasks.svh ====
`ifndef TB_SH_LSAB_TASKS_SVH
`define TB_SH_LSAB_TASKS_SVH

// Reference model, oldest expected queue entry first.
logic [WORD_W-1:0] exp_word [$];
logic              exp_last [$];
logic              exp_ok [$];

task report_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
	$display("error: %s got %h expected %h", name, got, exp);
	errors = errors + 1;
endtask

task finish_test(input string name, input int unsigned start_err);
	tests_run = tests_run + 1;
	if (errors != start_err)
	begin
		tests_failed = tests_failed + 1;
		$display("test %s: failed with %0d errors", name, errors - start_err);
	end
	else
		$display("test %s: passed", name);
endtask

// One MAC strobe, data held until the next one.
task send_word(input logic [WORD_W-1:0] w);
	@(negedge CLK);
	eth_data  = w;
	eth_write = 1'b1;
	@(negedge CLK);
	eth_write = 1'b0;
	repeat (EVENT_GAP) @(negedge CLK);
endtask

task send_frame(input int unsigned len, input logic ok);
	int unsigned i;
	logic [WORD_W-1:0] w;
	for (i = 0; i < len; i++)
	begin
		w = $random(seed);
		exp_word.push_back(w);
		exp_last.push_back(i == len - 1);     // Irq rides on the last word.
		exp_ok.push_back(ok);
		send_word(w);
	end
	@(negedge CLK);
	eth_frame_end = 1'b1;
	eth_frame_ok  = ok;
	@(negedge CLK);
	eth_frame_end = 1'b0;
	repeat (EVENT_GAP) @(negedge CLK);
endtask

// Wait for the oldest entry, compare it, then pop it.
task pop_expected();
	int unsigned t;
	logic [WORD_W-1:0] w;
	logic last;
	logic ok;
	w    = exp_word.pop_front();
	last = exp_last.pop_front();
	ok   = exp_ok.pop_front();
	t    = 0;
	while (rx_empty && t < WORD_LIMIT)
	begin
		@(negedge CLK);
		t = t + 1;
	end
	if (rx_empty)
	begin
		$display("timeout: expected word %h never reached the receive queue", w);
		errors = errors + 1;
	end
	else
	begin
		if (rx_word !== w) report_mismatch("rx_word", rx_word, w);
		if (rx_last !== last) report_mismatch("rx_last", 32'(rx_last), 32'(last));
		if (last && rx_ok !== ok) report_mismatch("rx_ok", 32'(rx_ok), 32'(ok));
		rx_pop = 1'b1;
		@(negedge CLK);
		rx_pop = 1'b0;
	end
endtask

task drain_model();
	while (exp_word.size() > 0)
		pop_expected();
endtask

task pulse_mac_read();
	@(negedge CLK);
	mac_read = 1'b1;
	@(negedge CLK);
	mac_read = 1'b0;
	repeat (EVENT_GAP) @(negedge CLK);
endtask

task pulse_collision();
	int unsigned t;
	@(negedge CLK);
	collision = 1'b1;
	@(negedge CLK);
	collision = 1'b0;
	t = 0;
	while (!err_req && t < WORD_LIMIT)
	begin
		@(negedge CLK);
		t = t + 1;
	end
	if (!err_req)
	begin
		$display("timeout: err_req did not rise after the collision");
		errors = errors + 1;
	end
endtask

task wait_read_idle();
	int unsigned t;
	t = 0;
	while (lsab_read && t < IDLE_LIMIT)
	begin
		@(negedge CLK);
		t = t + 1;
	end
	if (lsab_read)
	begin
		$display("timeout: lsab_read stayed high");
		errors = errors + 1;
	end
endtask

`endif

// ==== verif/tb_sh_lsab_bridge.sv ====
`timescale 1ns/1ns

module tb_sh_lsab_bridge;
	import sh_lsab_pkg::*;

	localparam logic [31:0] SEED          = 32'hee5473eb;
	localparam int unsigned RESET_CYCLES  = 8;
	localparam int unsigned EVENT_GAP     = 8;    // One slot rotation plus margin.
	localparam int unsigned FRAMES        = 6;
	localparam int unsigned OVF_FRAMES    = 4;
	localparam int unsigned OVF_LEN       = 5;    // 20 words, more than the queue.
	localparam int unsigned QUEUE_ENTRIES = 16;
	localparam int unsigned DRAIN_EXPECT  = 128;
	localparam int unsigned WORD_LIMIT    = 40;
	localparam int unsigned IDLE_LIMIT    = 600;  // Drain takes 512 cycles.

	logic              CLK = 1'b0;
	logic              RST = 1'b0;
	logic [TURN_W-1:0] lsab_turn = '0;
	logic [WORD_W-1:0] eth_data = '0;
	logic              eth_write = 1'b0;
	logic              eth_frame_end = 1'b0;
	logic              eth_frame_ok = 1'b0;
	logic              rx_pop = 1'b0;
	logic              collision = 1'b0;
	logic              mac_read = 1'b0;
	logic              err_ack = 1'b0;
	logic [WORD_W-1:0] rx_word;
	logic              rx_last;
	logic              rx_ok;
	logic              rx_empty;
	logic              rx_overflow;
	logic              err_req;
	logic              lsab_read;

	integer      seed;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int unsigned slot_read_cnt = 0;  // Cycles with lsab_read in turn 0.

	`include "tb_sh_lsab_tasks.svh"

	sh_lsab_bridge i_dut (
		.CLK           (CLK),
		.RST           (RST),
		.lsab_turn     (lsab_turn),
		.eth_data      (eth_data),
		.eth_write     (eth_write),
		.eth_frame_end (eth_frame_end),
		.eth_frame_ok  (eth_frame_ok),
		.rx_pop        (rx_pop),
		.rx_word       (rx_word),
		.rx_last       (rx_last),
		.rx_ok         (rx_ok),
		.rx_empty      (rx_empty),
		.rx_overflow   (rx_overflow),
		.collision     (collision),
		.mac_read      (mac_read),
		.err_ack       (err_ack),
		.err_req       (err_req),
		.lsab_read     (lsab_read)
	);

	initial
	begin
		forever #10 CLK = ~CLK;  // 20 ns period.
	end

	// Turn and lsab_read both hold their value until the next rising edge here.
	always @(negedge CLK)
	begin
		lsab_turn = lsab_turn + 2'd1;             // Rotate 0 to 3.
		if (lsab_read && lsab_turn == 2'd0)
			slot_read_cnt = slot_read_cnt + 1;    // One owned read cycle.
	end

	initial
	begin
		int unsigned i;
		int unsigned rnd;
		int unsigned start_err;
		int unsigned cnt_start;
		int unsigned cnt_end;
		seed         = SEED;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (RESET_CYCLES) @(negedge CLK);
		RST = 1'b1;
		@(negedge CLK);

		start_err = errors;
		if (rx_empty !== 1'b1) report_mismatch("rx_empty", 32'(rx_empty), 32'd1);
		if (rx_overflow !== 1'b0) report_mismatch("rx_overflow", 32'(rx_overflow), 32'd0);
		if (err_req !== 1'b0) report_mismatch("err_req", 32'(err_req), 32'd0);
		if (lsab_read !== 1'b0) report_mismatch("lsab_read", 32'(lsab_read), 32'd0);
		finish_test("reset_state", start_err);

		start_err = errors;
		for (i = 0; i < FRAMES; i++)
		begin
			rnd = $random(seed);
			cnt_end = 2 + rnd % 5;                // Frame length 2 to 6.
			rnd = $random(seed);
			send_frame(cnt_end, rnd[0]);
			drain_model();
		end
		if (rx_empty !== 1'b1) report_mismatch("rx_empty", 32'(rx_empty), 32'd1);
		finish_test("frame_transfer", start_err);

		start_err = errors;
		rnd = $random(seed);
		rnd = 3 + rnd % 6;                        // Number of read pulses.
		@(posedge CLK);
		cnt_start = slot_read_cnt;
		for (i = 0; i < rnd; i++)
			pulse_mac_read();
		wait_read_idle();
		@(posedge CLK);
		cnt_end = slot_read_cnt;
		if (cnt_end - cnt_start != rnd) report_mismatch("lsab_read slots", cnt_end - cnt_start, rnd);
		finish_test("regular_reads", start_err);

		start_err = errors;
		pulse_collision();
		@(posedge CLK);
		cnt_start = slot_read_cnt;
		@(negedge CLK);
		err_ack = 1'b1;
		@(negedge CLK);
		err_ack = 1'b0;
		if (err_req !== 1'b0) report_mismatch("err_req", 32'(err_req), 32'd0);
		wait_read_idle();
		@(posedge CLK);
		cnt_end = slot_read_cnt;
		if (cnt_end - cnt_start != DRAIN_EXPECT)
			report_mismatch("lsab_read slots", cnt_end - cnt_start, DRAIN_EXPECT);
		repeat (2 * EVENT_GAP) @(negedge CLK);
		if (lsab_read !== 1'b0) report_mismatch("lsab_read", 32'(lsab_read), 32'd0);
		finish_test("collision_drain", start_err);

		start_err = errors;
		for (i = 0; i < OVF_FRAMES; i++)
		begin
			rnd = $random(seed);
			send_frame(OVF_LEN, rnd[0]);
		end
		while (exp_word.size() > QUEUE_ENTRIES)
		begin
			exp_word.pop_back();                  // Dropped at the full queue.
			exp_last.pop_back();
			exp_ok.pop_back();
		end
		if (rx_overflow !== 1'b1) report_mismatch("rx_overflow", 32'(rx_overflow), 32'd1);
		drain_model();
		if (rx_empty !== 1'b1) report_mismatch("rx_empty", 32'(rx_empty), 32'd1);
		finish_test("overflow", start_err);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
